// File: bench/csr_input.txt
# columns: name, operation, address or pc, data, cause, expected value, all in hex
# pmp drives port a from the address column and port b from data, expected {0,rwx a,0,rwx b}
rst_mstatus     rd      300      0        0        00000000
rst_mtvec       rd      305      0        0        00000000
rst_mepc        rd      341      0        0        00000000
rst_mcause      rd      342      0        0        00000000
id_misa         rd      301      0        0        40000100
id_mimpid       rd      F13      0        0        00000001
id_mvendorid    rd      F11      0        0        00000000
unknown_addr    rd      7C0      0        0        00000000
wr_mscratch     wr      340      A5A55A5A 0        0
rd_mscratch     rd      340      0        0        A5A55A5A
wr_mepc         wr      341      12345678 0        0
rd_mepc         rd      341      0        0        12345678
wr_mie          wr      304      FFFFFFFF 0        0
rd_mie          rd      304      0        0        00000888
wr_mstatus      wr      300      FFFFFFFF 0        0
rd_mstatus      rd      300      0        0        00000088
wr_mtvec        wr      305      00000400 0        0
rd_mtvec        rd      305      0        0        00000400
wr_mstatus_mie  wr      300      00000008 0        0
trap_direct     trap    00000200 0        0000000B 00000400
trap_mepc       rd      341      0        0        00000200
trap_mcause     rd      342      0        0        0000000B
trap_mstatus    rd      300      0        0        00000080
mret_target     mret    0        0        0        00000200
mret_mstatus    rd      300      0        0        00000088
mret_mepc       rd      341      0        0        00000000
mret_mcause     rd      342      0        0        00000000
wr_vectored     wr      305      00000401 0        0
rd_vectored     rd      305      0        0        00000401
trap_vec_irq    trap    00000300 0        80000007 0000041C
vec_mcause      rd      342      0        0        80000007
mret_vec_irq    mret    0        0        0        00000300
trap_vec_exc    trap    00000304 0        00000002 00000400
mret_vec_exc    mret    0        0        0        00000304
wr_inhibit      wr      320      FFFFFFFF 0        0
rd_inhibit      rd      320      0        0        00000005
wr_mcycle       wr      B00      DEADBEEF 0        0
wr_mcycleh      wr      B80      00000012 0        0
rd_cycle        rd      C00      0        0        DEADBEEF
rd_cycleh       rd      C80      0        0        00000012
wr_minstret     wr      B02      CAFE0001 0        0
wr_minstreth    wr      B82      00000034 0        0
retire_frozen   retire  0        5        0        0
rd_instret      rd      C02      0        0        CAFE0001
rd_minstreth    rd      B82      0        0        00000034
wr_inhibit_cy   wr      320      00000001 0        0
clr_minstret    wr      B02      0        0        0
clr_minstreth   wr      B82      0        0        0
retire_count    retire  0        7        0        0
rd_count        rd      B02      0        0        00000007
rd_counth       rd      C82      0        0        00000000
rd_cycle_hold   rd      B00      0        0        DEADBEEF
pmp_code        pmp     00000000 00000FFC 0        00000055
pmp_code_edge   pmp     00000FFF 00001000 0        00000050
pmp_gap_low     pmp     00001000 0FFFFFFC 0        00000000
pmp_ram0        pmp     10000000 10000FFF 0        00000033
pmp_ram0_end    pmp     10001000 0FFFFFFF 0        00000000
pmp_ram1        pmp     20000000 20000FFC 0        00000033
pmp_ram1_end    pmp     20001000 1FFFFFFC 0        00000000
pmp_io_rw       pmp     FF000004 FF000007 0        00000033
pmp_io_ro       pmp     FF000008 FF00000C 0        00000010
pmp_io_below    pmp     FF000000 FFFFFFFC 0        00000000
pmp_mixed       pmp     FFFFFFFC 10000FFC 0        00000003
pmpcfg0         rd      3A0      0        0        809B809D
pmpcfg1         rd      3A1      0        0        9193809B
pmpcfg2         rd      3A2      0        0        00000088
pmpaddr0        rd      3B0      0        0        00000000
pmpaddr1        rd      3B1      0        0        00000400
pmpaddr2        rd      3B2      0        0        04000000
pmpaddr5        rd      3B5      0        0        08000400
pmpaddr6        rd      3B6      0        0        3FC00001
pmpaddr7        rd      3B7      0        0        3FC00002
pmpaddr8        rd      3B8      0        0        3FFFFFFF

// File: files.f
+incdir+src
src/csr_pkg.sv
src/pmp_pkg.sv
src/pmp_lookup.sv
src/csr_counters.sv
src/csr_file.sv
src/csr_unit.sv
bench/csr_unit_checker.sv
bench/csr_unit_tb.sv

// File: Makefile
TOP := csr_unit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f files.f --top-module csr_unit
	verilator --lint-only --timing -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) \
		--Mdir obj_dir -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// File: bench/csr_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb
    import csr_pkg::*;
();

    localparam int CHECK_TIMEOUT   = 10;
    localparam int WATCHDOG_CYCLES = 5000;
    localparam int MAX_STEPS       = 500;

    localparam logic [1:0] KIND_READ   = 2'd0;
    localparam logic [1:0] KIND_TRAP   = 2'd1;
    localparam logic [1:0] KIND_LOOKUP = 2'd2;

    logic         clk;
    logic         reset;
    logic         retired;
    word_t        pc;
    mcause_t      mcause;
    logic         mtrap;
    logic         mret;
    word_t        trap_addr;
    csr_addr_t    read_addr;
    logic         read_enable;
    word_t        read_data;
    csr_addr_t    write_addr;
    word_t        write_data;
    logic         write_enable;
    word_t        lookup_a_addr;
    word_t        lookup_b_addr;
    logic [2:0]   lookup_a_rwx;
    logic [2:0]   lookup_b_rwx;

    logic         check_valid;
    logic [1:0]   check_kind;
    logic [127:0] check_name;
    word_t        check_expected;
    int           checks_done;
    int           check_errors;
    int           step_errors;

    csr_unit UUT (
        .clk_i              (clk),
        .reset_i            (reset),
        .retired_i          (retired),
        .pc_i               (pc),
        .mcause_i           (mcause),
        .mtrap_i            (mtrap),
        .mret_i             (mret),
        .trap_addr_o        (trap_addr),
        .csr_read_addr_i    (read_addr),
        .csr_read_enable_i  (read_enable),
        .csr_read_data_o    (read_data),
        .csr_write_addr_i   (write_addr),
        .csr_write_data_i   (write_data),
        .csr_write_enable_i (write_enable),
        .lookup_a_addr_i    (lookup_a_addr),
        .lookup_a_rwx_o     (lookup_a_rwx),
        .lookup_b_addr_i    (lookup_b_addr),
        .lookup_b_rwx_o     (lookup_b_rwx)
    );

    csr_unit_checker result_check (
        .clk_i         (clk),
        .mtrap_i       (mtrap),
        .mret_i        (mret),
        .read_data_i   (read_data),
        .trap_addr_i   (trap_addr),
        .rwx_a_i       (lookup_a_rwx),
        .rwx_b_i       (lookup_b_rwx),
        .check_valid_i (check_valid),
        .check_kind_i  (check_kind),
        .test_name_i   (check_name),
        .expected_i    (check_expected),
        .checks_done_o (checks_done),
        .error_count_o (check_errors)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic run_check(input logic [1:0] kind, input logic [127:0] name,
                             input word_t expected);
        int start;
        int waited;
        start          = checks_done;
        waited         = 0;
        check_kind     = kind;
        check_name     = name;
        check_expected = expected;
        check_valid    = 1'b1;
        while (checks_done == start && waited < CHECK_TIMEOUT) begin
            next_cycle();
            waited++;
        end
        check_valid = 1'b0;
        if (checks_done == start) begin
            $display("checker gave no response for step %0s", name);
            step_errors++;
        end
    endtask

    task automatic write_csr(input word_t addr, input word_t data);
        write_addr   = csr_addr_t'(addr[11:0]);
        write_data   = data;
        write_enable = 1'b1;
        next_cycle();
        write_enable = 1'b0;
    endtask

    // read data arrives one cycle later and holds until the next edge
    task automatic read_csr(input word_t addr, input logic [127:0] name, input word_t expected);
        read_addr   = csr_addr_t'(addr[11:0]);
        read_enable = 1'b1;
        next_cycle();
        read_enable = 1'b0;
        run_check(KIND_READ, name, expected);
    endtask

    task automatic enter_trap(input word_t trap_pc, input word_t cause,
                              input logic [127:0] name, input word_t expected);
        pc     = trap_pc;
        mcause = mcause_t'(cause);
        mtrap  = 1'b1;
        run_check(KIND_TRAP, name, expected);
        mtrap  = 1'b0;
    endtask

    task automatic return_from_trap(input logic [127:0] name, input word_t expected);
        mret = 1'b1;
        run_check(KIND_TRAP, name, expected);
        mret = 1'b0;
    endtask

    // single-cycle pulses with an idle cycle between them
    task automatic pulse_retired(input word_t count);
        for (int i = 0; i < count; i++) begin
            retired = 1'b1;
            next_cycle();
            retired = 1'b0;
            next_cycle();
        end
    endtask

    task automatic lookup_pmp(input word_t addr_a, input word_t addr_b,
                              input logic [127:0] name, input word_t expected);
        lookup_a_addr = addr_a;
        lookup_b_addr = addr_b;
        run_check(KIND_LOOKUP, name, expected);
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < WATCHDOG_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("simulation still running after %0d cycles", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : stimulus
        int           fd;
        int           fields;
        int           steps;
        int           total;
        string        line;
        logic [127:0] name_f;
        logic [127:0] op_f;
        word_t        addr_f;
        word_t        data_f;
        word_t        cause_f;
        word_t        expected_f;

        reset          = 1'b1;
        retired        = 1'b0;
        pc             = '0;
        mcause         = '0;
        mtrap          = 1'b0;
        mret           = 1'b0;
        read_addr      = csr_addr_t'(12'h000);
        read_enable    = 1'b0;
        write_addr     = csr_addr_t'(12'h000);
        write_data     = '0;
        write_enable   = 1'b0;
        lookup_a_addr  = '0;
        lookup_b_addr  = '0;
        check_valid    = 1'b0;
        check_kind     = KIND_READ;
        check_name     = '0;
        check_expected = '0;
        step_errors    = 0;
        steps          = 0;

        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        fd = $fopen("bench/csr_input.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/csr_input.txt");
            step_errors++;
        end else begin
            while (!$feof(fd) && steps < MAX_STEPS) begin
                line = "";
                if ($fgets(line, fd) == 0) begin
                    break;
                end
                if (line.len() > 0 && line[0] == "#") begin
                    continue;
                end
                fields = $sscanf(line, "%s %s %h %h %h %h",
                                 name_f, op_f, addr_f, data_f, cause_f, expected_f);
                if (fields != 6) begin
                    continue;
                end
                steps++;
                if (op_f == "rd") begin
                    read_csr(addr_f, name_f, expected_f);
                end else if (op_f == "wr") begin
                    write_csr(addr_f, data_f);
                end else if (op_f == "trap") begin
                    enter_trap(addr_f, cause_f, name_f, expected_f);
                end else if (op_f == "mret") begin
                    return_from_trap(name_f, expected_f);
                end else if (op_f == "retire") begin
                    pulse_retired(data_f);
                end else if (op_f == "pmp") begin
                    lookup_pmp(addr_f, data_f, name_f, expected_f);
                end else begin
                    $display("step %0s has an unknown operation %0s", name_f, op_f);
                    step_errors++;
                end
            end
            $fclose(fd);
        end

        next_cycle();
        total = check_errors + step_errors;
        $display("steps %0d, checks %0d, errors %0d", steps, checks_done, total);
        if (total == 0 && steps > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/csr_unit_checker.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_checker
    import csr_pkg::*;
(
    input  wire logic         clk_i,
    input  wire logic         mtrap_i,
    input  wire logic         mret_i,
    input  wire word_t        read_data_i,
    input  wire word_t        trap_addr_i,
    input  wire logic [2:0]   rwx_a_i,
    input  wire logic [2:0]   rwx_b_i,
    input  wire logic         check_valid_i,
    input  wire logic [1:0]   check_kind_i,
    input  wire logic [127:0] test_name_i,
    input  wire word_t        expected_i,
    output int                checks_done_o,
    output int                error_count_o
);

    localparam logic [1:0] KIND_READ   = 2'd0;
    localparam logic [1:0] KIND_TRAP   = 2'd1;
    localparam logic [1:0] KIND_LOOKUP = 2'd2;

    word_t actual;
    int    new_errors;

    initial begin
        checks_done_o = 0;
        error_count_o = 0;
    end

    // compare mid-cycle while the outputs are stable
    always @(negedge clk_i) begin
        new_errors = 0;
        if (check_valid_i) begin
            case (check_kind_i)
                KIND_READ:   actual = read_data_i;
                KIND_TRAP:   actual = trap_addr_i;
                // one nibble per lookup port with port a on top
                KIND_LOOKUP: actual = {24'b0, 1'b0, rwx_a_i, 1'b0, rwx_b_i};
                default:     actual = '0;
            endcase
            if (actual !== expected_i) begin
                $display("Fail %0s expected %h actual %h", test_name_i, expected_i, actual);
                new_errors++;
            end
            checks_done_o <= checks_done_o + 1;
        end

        // trap target must stay zero outside trap and return cycles
        if (!mtrap_i && !mret_i && trap_addr_i !== '0) begin
            $display("Fail idle_trap_addr expected %h actual %h", 32'h0, trap_addr_i);
            new_errors++;
        end
        error_count_o <= error_count_o + new_errors;
    end

endmodule

`default_nettype wire

// File: src/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit
    import csr_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      reset_i,
    input  wire logic      retired_i,

    // trap port
    input  wire word_t     pc_i,
    input  wire mcause_t   mcause_i,
    input  wire logic      mtrap_i,
    input  wire logic      mret_i,
    output word_t          trap_addr_o,

    // csr access
    input  wire csr_addr_t csr_read_addr_i,
    input  wire logic      csr_read_enable_i,
    output word_t          csr_read_data_o,
    input  wire csr_addr_t csr_write_addr_i,
    input  wire word_t     csr_write_data_i,
    input  wire logic      csr_write_enable_i,

    // pmp lookups
    input  wire word_t     lookup_a_addr_i,
    output logic [2:0]     lookup_a_rwx_o,
    input  wire word_t     lookup_b_addr_i,
    output logic [2:0]     lookup_b_rwx_o
);

    dword_t cycle_count;
    dword_t time_count;
    dword_t instret_count;
    word_t  inhibit;

    csr_file csr_file (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .pc_i           (pc_i),
        .mcause_i       (mcause_i),
        .mtrap_i        (mtrap_i),
        .mret_i         (mret_i),
        .trap_addr_o    (trap_addr_o),
        .read_addr_i    (csr_read_addr_i),
        .read_enable_i  (csr_read_enable_i),
        .read_data_o    (csr_read_data_o),
        .write_addr_i   (csr_write_addr_i),
        .write_data_i   (csr_write_data_i),
        .write_enable_i (csr_write_enable_i),
        .cycle_i        (cycle_count),
        .time_i         (time_count),
        .instret_i      (instret_count),
        .inhibit_o      (inhibit)
    );

    // counter halves share the csr write port
    csr_counters csr_counters (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .retired_i      (retired_i),
        .inhibit_i      (inhibit),
        .write_addr_i   (csr_write_addr_i),
        .write_data_i   (csr_write_data_i),
        .write_enable_i (csr_write_enable_i),
        .cycle_o        (cycle_count),
        .time_o         (time_count),
        .instret_o      (instret_count)
    );

    pmp_lookup lookup_a (
        .addr_i (lookup_a_addr_i),
        .rwx_o  (lookup_a_rwx_o)
    );

    pmp_lookup lookup_b (
        .addr_i (lookup_b_addr_i),
        .rwx_o  (lookup_b_rwx_o)
    );

endmodule

`default_nettype wire

// File: src/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file
    import csr_pkg::*;
    import pmp_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      reset_i,

    // trap port
    input  wire word_t     pc_i,
    input  wire mcause_t   mcause_i,
    input  wire logic      mtrap_i,
    input  wire logic      mret_i,
    output word_t          trap_addr_o,

    // read port
    input  wire csr_addr_t read_addr_i,
    input  wire logic      read_enable_i,
    output word_t          read_data_o,

    // write port
    input  wire csr_addr_t write_addr_i,
    input  wire word_t     write_data_i,
    input  wire logic      write_enable_i,

    // counters
    input  wire dword_t    cycle_i,
    input  wire dword_t    time_i,
    input  wire dword_t    instret_i,
    output word_t          inhibit_o
);

    // rv32 with only the I extension
    localparam word_t MISA_VALUE   = 32'h4000_0100;
    localparam word_t MIMPID_VALUE = 32'h0000_0001;
    // only CY and IR can be inhibited
    localparam word_t INHIBIT_MASK = 32'h0000_0005;

    mtvec_t   mtvec_r;
    word_t    mcountinhibit_r;
    word_t    mscratch_r;
    word_t    mepc_r;
    mcause_t  mcause_r;
    logic     mstatus_mie_r;
    logic     mstatus_mpie_r;
    logic     meie_r;
    logic     mtie_r;
    logic     msie_r;

    mstatus_t mstatus_rd;
    mstatus_t mstatus_wr;
    mi_t      mie_rd;
    mi_t      mie_wr;

    always_comb begin
        mstatus_rd      = '0;
        mstatus_rd.mie  = mstatus_mie_r;
        mstatus_rd.mpie = mstatus_mpie_r;
        mie_rd          = '0;
        mie_rd.mei      = meie_r;
        mie_rd.mti      = mtie_r;
        mie_rd.msi      = msie_r;
    end

    assign mstatus_wr = mstatus_t'(write_data_i);
    assign mie_wr     = mi_t'(write_data_i[15:0]);
    assign inhibit_o  = mcountinhibit_r;

    // vectored mode only offsets interrupts
    always_comb begin
        trap_addr_o = '0;
        if (mtrap_i) begin
            if (mtvec_r.mode == MTVEC_MODE_VECTORED && mcause_i.is_interrupt) begin
                trap_addr_o = {mtvec_r.base + mcause_i.exception_code[29:0], 2'b00};
            end else begin
                trap_addr_o = {mtvec_r.base, 2'b00};
            end
        end else if (mret_i) begin
            trap_addr_o = mepc_r;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mtvec_r         <= '{base: '0, mode: MTVEC_MODE_DIRECT};
            mcountinhibit_r <= '0;
            mscratch_r      <= '0;
            mepc_r          <= '0;
            mcause_r        <= '0;
            mstatus_mie_r   <= 1'b0;
            mstatus_mpie_r  <= 1'b0;
            meie_r          <= 1'b0;
            mtie_r          <= 1'b0;
            msie_r          <= 1'b0;
        end else begin
            if (write_enable_i) begin
                case (write_addr_i)
                    CSR_MTVEC: begin
                        mtvec_r.base <= write_data_i[31:2];
                        mtvec_r.mode <= (write_data_i[1:0] == 2'b01) ?
                                        MTVEC_MODE_VECTORED : MTVEC_MODE_DIRECT;
                    end
                    CSR_MCOUNTINHIBIT: mcountinhibit_r <= write_data_i & INHIBIT_MASK;
                    CSR_MSCRATCH:      mscratch_r      <= write_data_i;
                    CSR_MEPC:          mepc_r          <= write_data_i;
                    CSR_MCAUSE:        mcause_r        <= mcause_t'(write_data_i);
                    CSR_MSTATUS: begin
                        mstatus_mie_r  <= mstatus_wr.mie;
                        mstatus_mpie_r <= mstatus_wr.mpie;
                    end
                    CSR_MIE: begin
                        meie_r <= mie_wr.mei;
                        mtie_r <= mie_wr.mti;
                        msie_r <= mie_wr.msi;
                    end
                    default: ;
                endcase
            end

            // trap state changes take priority over a write
            if (mtrap_i) begin
                mepc_r         <= pc_i;
                mcause_r       <= mcause_i;
                mstatus_mpie_r <= mstatus_mie_r;
                mstatus_mie_r  <= 1'b0;
            end else if (mret_i) begin
                mepc_r         <= '0;
                mcause_r       <= '0;
                mstatus_mie_r  <= mstatus_mpie_r;
                mstatus_mpie_r <= 1'b1;
            end
        end
    end

    // registered read, zero when idle
    always_ff @(posedge clk_i) begin
        if (reset_i || !read_enable_i) begin
            read_data_o <= '0;
        end else begin
            case (read_addr_i)
                CSR_MISA:                 read_data_o <= MISA_VALUE;
                CSR_MIMPID:               read_data_o <= MIMPID_VALUE;
                CSR_MSTATUS:              read_data_o <= mstatus_rd;
                CSR_MTVEC:                read_data_o <= mtvec_r;
                CSR_MCOUNTINHIBIT:        read_data_o <= mcountinhibit_r;
                CSR_MSCRATCH:             read_data_o <= mscratch_r;
                CSR_MEPC:                 read_data_o <= mepc_r;
                CSR_MCAUSE:               read_data_o <= mcause_r;
                CSR_MIE:                  read_data_o <= {16'b0, mie_rd};
                CSR_CYCLE, CSR_MCYCLE:    read_data_o <= cycle_i[31:0];
                CSR_CYCLEH, CSR_MCYCLEH:  read_data_o <= cycle_i[63:32];
                CSR_TIME:                 read_data_o <= time_i[31:0];
                CSR_TIMEH:                read_data_o <= time_i[63:32];
                CSR_INSTRET, CSR_MINSTRET:   read_data_o <= instret_i[31:0];
                CSR_INSTRETH, CSR_MINSTRETH: read_data_o <= instret_i[63:32];
                // four cfg bytes per pmpcfg register
                CSR_PMPCFG0: read_data_o <= {PMP_TABLE[3].cfg, PMP_TABLE[2].cfg,
                                             PMP_TABLE[1].cfg, PMP_TABLE[0].cfg};
                CSR_PMPCFG0 + 12'd1: read_data_o <= {PMP_TABLE[7].cfg, PMP_TABLE[6].cfg,
                                                     PMP_TABLE[5].cfg, PMP_TABLE[4].cfg};
                CSR_PMPCFG0 + 12'd2: read_data_o <= {24'b0, PMP_TABLE[8].cfg};
                CSR_PMPADDR0:        read_data_o <= PMP_TABLE[0].addr;
                CSR_PMPADDR0 + 12'd1: read_data_o <= PMP_TABLE[1].addr;
                CSR_PMPADDR0 + 12'd2: read_data_o <= PMP_TABLE[2].addr;
                CSR_PMPADDR0 + 12'd3: read_data_o <= PMP_TABLE[3].addr;
                CSR_PMPADDR0 + 12'd4: read_data_o <= PMP_TABLE[4].addr;
                CSR_PMPADDR0 + 12'd5: read_data_o <= PMP_TABLE[5].addr;
                CSR_PMPADDR0 + 12'd6: read_data_o <= PMP_TABLE[6].addr;
                CSR_PMPADDR0 + 12'd7: read_data_o <= PMP_TABLE[7].addr;
                CSR_PMPADDR0 + 12'd8: read_data_o <= PMP_TABLE[8].addr;
                // ids, mip and trap values all read as zero
                default:              read_data_o <= '0;
            endcase
        end
    end

    assert property (@(posedge clk_i) disable iff (reset_i) !(mtrap_i && mret_i))
        else $error("trap and trap return in the same cycle");

    assert property (@(posedge clk_i) disable iff (reset_i) !(mtrap_i && write_enable_i))
        else $error("csr write during trap entry");

endmodule

`default_nettype wire

// File: src/csr_counters.sv
`timescale 1ns/1ps
`default_nettype none

module csr_counters
    import csr_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      reset_i,
    input  wire logic      retired_i,
    input  wire word_t     inhibit_i,
    input  wire csr_addr_t write_addr_i,
    input  wire word_t     write_data_i,
    input  wire logic      write_enable_i,
    output dword_t         cycle_o,
    output dword_t         time_o,
    output dword_t         instret_o
);

    dword_t cycle_r,   cycle_n;
    dword_t time_r,    time_n;
    dword_t instret_r, instret_n;

    always_comb begin
        cycle_n   = inhibit_i[0] ? cycle_r : cycle_r + 1'b1;
        time_n    = time_r + 1'b1;
        instret_n = (retired_i && !inhibit_i[2]) ? instret_r + 1'b1 : instret_r;

        // a write replaces one half while the other keeps counting
        if (write_enable_i) begin
            case (write_addr_i)
                CSR_CYCLE, CSR_MCYCLE:       cycle_n[31:0]    = write_data_i;
                CSR_CYCLEH, CSR_MCYCLEH:     cycle_n[63:32]   = write_data_i;
                CSR_TIME:                    time_n[31:0]     = write_data_i;
                CSR_TIMEH:                   time_n[63:32]    = write_data_i;
                CSR_INSTRET, CSR_MINSTRET:   instret_n[31:0]  = write_data_i;
                CSR_INSTRETH, CSR_MINSTRETH: instret_n[63:32] = write_data_i;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cycle_r   <= '0;
            time_r    <= '0;
            instret_r <= '0;
        end else begin
            cycle_r   <= cycle_n;
            time_r    <= time_n;
            instret_r <= instret_n;
        end
    end

    assign cycle_o   = cycle_r;
    assign time_o    = time_r;
    assign instret_o = instret_r;

endmodule

`default_nettype wire

// File: src/pmp_lookup.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_defines.svh"

module pmp_lookup
    import csr_pkg::*;
    import pmp_pkg::*;
(
    input  wire word_t      addr_i,
    output logic [2:0]      rwx_o
);

    word_t                     word_addr;
    logic [`PMP_ENTRIES-2:0]   hit;

    // table holds word addresses
    assign word_addr = {2'b00, addr_i[`XLEN-1:2]};

    // match each entry except the fallback
    always_comb begin
        for (int i = 0; i < `PMP_ENTRIES - 1; i++) begin
            if (PMP_TABLE[i].cfg.mode == PMP_NA4) begin
                hit[i] = (word_addr == PMP_TABLE[i].addr);
            end else begin
                // range style, bounded above by the next entry
                hit[i] = (word_addr < PMP_TABLE[i + 1].addr);
            end
        end
    end

    // lowest matching entry wins
    always_comb begin
        rwx_o = PMP_TABLE[`PMP_ENTRIES - 1].cfg.rwx;
        for (int i = `PMP_ENTRIES - 2; i >= 0; i--) begin
            if (hit[i]) begin
                rwx_o = PMP_TABLE[i].cfg.rwx;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/pmp_pkg.sv
`default_nettype none

`include "riscv_defines.svh"

package pmp_pkg;

    typedef enum logic [1:0] {
        PMP_OFF   = 2'b00,
        PMP_TOR   = 2'b01,
        PMP_NA4   = 2'b10,
        PMP_NAPOT = 2'b11
    } pmp_mode_t;

    // permission bits as laid out in a pmpcfg byte
    localparam logic [2:0] PMP_R = 3'b001;
    localparam logic [2:0] PMP_W = 3'b010;
    localparam logic [2:0] PMP_X = 3'b100;

    typedef struct packed {
        logic       locked;
        logic [1:0] reserved;
        pmp_mode_t  mode;
        logic [2:0] rwx;
    } pmp_cfg_t;

    // addr holds the word address, like pmpaddr
    typedef struct packed {
        logic [`XLEN-1:0] addr;
        pmp_cfg_t         cfg;
    } pmp_entry_t;

    function automatic pmp_entry_t pmp_region(input logic [`XLEN-1:0] byte_addr,
                                              input pmp_mode_t mode,
                                              input logic [2:0] rwx);
        return '{addr: byte_addr >> 2, cfg: '{locked: 1'b1, reserved: 2'b00, mode: mode, rwx: rwx}};
    endfunction

    // range entries end where the next entry starts
    localparam pmp_entry_t [0:`PMP_ENTRIES-1] PMP_TABLE = '{
        pmp_region(32'h0000_0000, PMP_NAPOT, PMP_R | PMP_X),
        pmp_region(32'h0000_1000, PMP_OFF,   3'b000),
        pmp_region(32'h1000_0000, PMP_NAPOT, PMP_R | PMP_W),
        pmp_region(32'h1000_1000, PMP_OFF,   3'b000),
        pmp_region(32'h2000_0000, PMP_NAPOT, PMP_R | PMP_W),
        pmp_region(32'h2000_1000, PMP_OFF,   3'b000),
        // single words of the i/o page
        pmp_region(32'hFF00_0004, PMP_NA4,   PMP_R | PMP_W),
        pmp_region(32'hFF00_0008, PMP_NA4,   PMP_R),
        // catch-all, no access
        pmp_region(32'hFFFF_FFFF, PMP_TOR,   3'b000)
    };

endpackage

`default_nettype wire

// File: src/csr_pkg.sv
`default_nettype none

`include "riscv_defines.svh"

package csr_pkg;

    typedef logic [`XLEN-1:0]  word_t;
    typedef logic [`CNT_W-1:0] dword_t;

    // machine mode csr addresses
    typedef enum logic [11:0] {
        CSR_MSTATUS       = 12'h300,
        CSR_MISA          = 12'h301,
        CSR_MIE           = 12'h304,
        CSR_MTVEC         = 12'h305,
        CSR_MCOUNTINHIBIT = 12'h320,
        CSR_MSCRATCH      = 12'h340,
        CSR_MEPC          = 12'h341,
        CSR_MCAUSE        = 12'h342,
        CSR_MTVAL         = 12'h343,
        CSR_MIP           = 12'h344,
        CSR_MTINST        = 12'h34A,
        CSR_MTVAL2        = 12'h34B,
        CSR_PMPCFG0       = 12'h3A0,
        CSR_PMPADDR0      = 12'h3B0,
        CSR_MCYCLE        = 12'hB00,
        CSR_MINSTRET      = 12'hB02,
        CSR_MCYCLEH       = 12'hB80,
        CSR_MINSTRETH     = 12'hB82,
        CSR_CYCLE         = 12'hC00,
        CSR_TIME          = 12'hC01,
        CSR_INSTRET       = 12'hC02,
        CSR_CYCLEH        = 12'hC80,
        CSR_TIMEH         = 12'hC81,
        CSR_INSTRETH      = 12'hC82,
        CSR_MVENDORID     = 12'hF11,
        CSR_MARCHID       = 12'hF12,
        CSR_MIMPID        = 12'hF13,
        CSR_MHARTID       = 12'hF14
    } csr_addr_t;

    // only mie (bit 3) and mpie (bit 7) are implemented
    typedef struct packed {
        logic [23:0] reserved_hi;
        logic        mpie;
        logic [2:0]  reserved_mid;
        logic        mie;
        logic [2:0]  reserved_lo;
    } mstatus_t;

    typedef struct packed {
        logic        is_interrupt;
        logic [30:0] exception_code;
    } mcause_t;

    typedef enum logic [1:0] {
        MTVEC_MODE_DIRECT   = 2'b00,
        MTVEC_MODE_VECTORED = 2'b01
    } mtvec_mode_t;

    typedef struct packed {
        logic [29:0] base;
        mtvec_mode_t mode;
    } mtvec_t;

    // layout shared by mie and mip
    typedef struct packed {
        logic [3:0] reserved_15_12;
        logic       mei;
        logic [2:0] reserved_10_8;
        logic       mti;
        logic [2:0] reserved_6_4;
        logic       msi;
        logic [2:0] reserved_2_0;
    } mi_t;

endpackage

`default_nettype wire

// File: src/riscv_defines.svh
`ifndef RISCV_DEFINES_SVH
`define RISCV_DEFINES_SVH

// width of a machine register
`define XLEN 32

// width of the cycle, time and instret counters
`define CNT_W 64

// regions in the fixed pmp table
`define PMP_ENTRIES 9

`endif
